/* logic/mem_bridge_pkg.sv */
package mem_bridge_pkg;

    // requester side.
    localparam int WIDE_DATA_WIDTH = 128;
    localparam int WIDE_ADDR_WIDTH = 8;

    // narrow RAM side.
    localparam int NARROW_DATA_WIDTH = 32;
    localparam int NARROW_ADDR_WIDTH = 10; // wide address plus 2-bit beat index.

    localparam int TAG_WIDTH = 4;

    localparam int WIDE_BYTEEN_WIDTH = WIDE_DATA_WIDTH / 8;
    localparam int NARROW_BYTEEN_WIDTH = NARROW_DATA_WIDTH / 8;

    typedef logic [WIDE_DATA_WIDTH-1:0] wide_data_t;
    typedef logic [WIDE_BYTEEN_WIDTH-1:0] wide_byteen_t;
    typedef logic [WIDE_ADDR_WIDTH-1:0] wide_addr_t;

    typedef logic [NARROW_DATA_WIDTH-1:0] narrow_data_t;
    typedef logic [NARROW_BYTEEN_WIDTH-1:0] narrow_byteen_t;
    typedef logic [NARROW_ADDR_WIDTH-1:0] narrow_addr_t;

    typedef logic [TAG_WIDTH-1:0] tag_t; // request identifier.

endpackage

/* logic/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10,
    parameter int TAG_WIDTH = 4
);
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

    // request channel.
    logic req_valid;
    logic [ADDR_WIDTH-1:0] req_addr;
    logic req_rw; // 1 for write.
    logic [BYTEEN_WIDTH-1:0] req_byteen;
    logic [DATA_WIDTH-1:0] req_data;
    logic [TAG_WIDTH-1:0] req_tag;
    logic req_ready;

    // response channel.
    logic rsp_valid;
    logic [DATA_WIDTH-1:0] rsp_data;
    logic [TAG_WIDTH-1:0] rsp_tag;
    logic rsp_ready;

    modport requester (
        output req_valid,
        output req_addr,
        output req_rw,
        output req_byteen,
        output req_data,
        output req_tag,
        input req_ready,
        input rsp_valid,
        input rsp_data,
        input rsp_tag,
        output rsp_ready
    );

    modport responder (
        input req_valid,
        input req_addr,
        input req_rw,
        input req_byteen,
        input req_data,
        input req_tag,
        output req_ready,
        output rsp_valid,
        output rsp_data,
        output rsp_tag,
        input rsp_ready
    );

endinterface

/* logic/mem_req_queue.sv */
`timescale 1ns/1ps

module mem_req_queue #(
    parameter int DATA_WIDTH = 128,
    parameter int ADDR_WIDTH = 8,
    parameter int TAG_WIDTH = 4,
    parameter int DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic [ADDR_WIDTH-1:0] in_addr,
    input logic in_rw,
    input logic [DATA_WIDTH/8-1:0] in_byteen,
    input logic [DATA_WIDTH-1:0] in_data,
    input logic [TAG_WIDTH-1:0] in_tag,
    output logic in_ready,
    mem_bus_if.requester out
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ADDR_WIDTH-1:0] addr_q [DEPTH];
    logic rw_q [DEPTH];
    logic [DATA_WIDTH/8-1:0] byteen_q [DEPTH];
    logic [DATA_WIDTH-1:0] data_q [DEPTH];
    logic [TAG_WIDTH-1:0] tag_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic in_fire;
    logic out_fire;

    assign in_ready = (count != CNT_W'(DEPTH)); // only the count, never the output side.
    assign in_fire = in_valid && in_ready;
    assign out_fire = out.req_valid && out.req_ready;

    assign out.req_valid = (count != '0);
    assign out.req_addr = addr_q[rd_ptr];
    assign out.req_rw = rw_q[rd_ptr];
    assign out.req_byteen = byteen_q[rd_ptr];
    assign out.req_data = data_q[rd_ptr];
    assign out.req_tag = tag_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_fire) begin
            addr_q[wr_ptr] <= in_addr;
            rw_q[wr_ptr] <= in_rw;
            byteen_q[wr_ptr] <= in_byteen;
            data_q[wr_ptr] <= in_data;
            tag_q[wr_ptr] <= in_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (in_fire) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
            end
            if (out_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in_fire && !out_fire) begin
                count <= count + 1'b1;
            end else if (out_fire && !in_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH));

endmodule

/* logic/mem_width_adapter.sv */
`timescale 1ns/1ps

module mem_width_adapter #(
    parameter int SRC_DATA_WIDTH = 128,
    parameter int DST_DATA_WIDTH = 32,
    parameter int SRC_ADDR_WIDTH = 8,
    parameter int DST_ADDR_WIDTH = 10
) (
    input logic clk,
    input logic reset,
    mem_bus_if.responder src,
    mem_bus_if.requester dst
);
    import mem_bridge_pkg::*;

    localparam int RATIO = SRC_DATA_WIDTH / DST_DATA_WIDTH;
    localparam int IDX_W = $clog2(RATIO);
    localparam int DST_BYTES = DST_DATA_WIDTH / 8;
    localparam logic [IDX_W-1:0] LAST = IDX_W'(RATIO - 1);

    logic [IDX_W-1:0] req_ctr;
    logic [IDX_W-1:0] rsp_ctr;
    logic [RATIO-1:0][DST_DATA_WIDTH-1:0] req_data_w;
    logic [RATIO-1:0][DST_BYTES-1:0] req_byteen_w;
    logic [RATIO-2:0][DST_DATA_WIDTH-1:0] beat_store; // earlier read beats, beat 0 lowest.
    tag_t first_tag;
    logic req_fire;
    logic rsp_fire;

    assign req_data_w = src.req_data;
    assign req_byteen_w = src.req_byteen;

    assign req_fire = dst.req_valid && dst.req_ready;
    assign rsp_fire = dst.rsp_valid && dst.rsp_ready;

    // request path, one narrow beat per slice.
    assign dst.req_valid = src.req_valid;
    assign dst.req_addr = DST_ADDR_WIDTH'({src.req_addr, req_ctr});
    assign dst.req_rw = src.req_rw;
    assign dst.req_byteen = req_byteen_w[req_ctr];
    assign dst.req_data = req_data_w[req_ctr];
    assign dst.req_tag = src.req_tag;

    // the wide request retires with its last beat.
    assign src.req_ready = dst.req_ready && (req_ctr == LAST);

    // response path.
    assign src.rsp_valid = dst.rsp_valid && (rsp_ctr == LAST);
    assign src.rsp_data = {dst.rsp_data, beat_store};
    assign src.rsp_tag = dst.rsp_tag;
    assign dst.rsp_ready = src.rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_ctr <= '0;
            rsp_ctr <= '0;
        end else begin
            if (req_fire) begin
                req_ctr <= req_ctr + 1'b1;
            end
            if (rsp_fire) begin
                rsp_ctr <= rsp_ctr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire && (rsp_ctr != LAST)) begin
            beat_store[rsp_ctr] <= dst.rsp_data;
        end
        if (rsp_fire && (rsp_ctr == '0)) begin
            first_tag <= dst.rsp_tag;
        end
    end

    // a later beat with another tag means the RAM returned out of order.
    a_rsp_in_order: assert property (@(posedge clk) disable iff (reset)
        (rsp_fire && (rsp_ctr != '0)) |-> (dst.rsp_tag == first_tag))
        else $error("%t out-of-order narrow response, got %0d expected %0d",
                    $time, dst.rsp_tag, first_tag);

    // the queue must hold a stalled wide request steady.
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (dst.req_valid && !dst.req_ready) |=>
            (dst.req_valid && $stable(dst.req_addr) && $stable(dst.req_rw)
             && $stable(dst.req_byteen) && $stable(dst.req_data)
             && $stable(dst.req_tag)));

endmodule

/* logic/narrow_ram.sv */
`timescale 1ns/1ps

module narrow_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input logic clk,
    input logic reset,
    mem_bus_if.responder bus
);
    import mem_bridge_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int BYTES = NARROW_DATA_WIDTH / 8;

    narrow_data_t mem [DEPTH];

    logic rsp_valid_r;
    narrow_data_t rsp_data_r;
    tag_t rsp_tag_r;
    logic ready;
    logic accept;

    assign ready = !rsp_valid_r || bus.rsp_ready; // slot free or draining.
    assign accept = bus.req_valid && ready;

    assign bus.req_ready = ready;
    assign bus.rsp_valid = rsp_valid_r;
    assign bus.rsp_data = rsp_data_r;
    assign bus.rsp_tag = rsp_tag_r;

    always_ff @(posedge clk) begin
        if (accept && bus.req_rw) begin
            for (int i = 0; i < BYTES; i++) begin
                if (bus.req_byteen[i]) begin
                    mem[bus.req_addr][8*i +: 8] <= bus.req_data[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid_r <= 1'b0;
        end else if (accept) begin
            rsp_valid_r <= !bus.req_rw; // writes make no response.
        end else if (bus.rsp_ready) begin
            rsp_valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !bus.req_rw) begin
            rsp_data_r <= mem[bus.req_addr];
            rsp_tag_r <= bus.req_tag;
        end
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        (rsp_valid_r && !bus.rsp_ready) |=>
            (rsp_valid_r && $stable(rsp_data_r) && $stable(rsp_tag_r)));

endmodule

/* logic/mem_bridge_top.sv */
`timescale 1ns/1ps

module mem_bridge_top (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input mem_bridge_pkg::wide_addr_t req_addr,
    input logic req_rw,
    input mem_bridge_pkg::wide_byteen_t req_byteen,
    input mem_bridge_pkg::wide_data_t req_data,
    input mem_bridge_pkg::tag_t req_tag,
    output logic req_ready,
    output logic rsp_valid,
    output mem_bridge_pkg::wide_data_t rsp_data,
    output mem_bridge_pkg::tag_t rsp_tag,
    input logic rsp_ready
);
    import mem_bridge_pkg::*;

    mem_bus_if #(
        .DATA_WIDTH(WIDE_DATA_WIDTH),
        .ADDR_WIDTH(WIDE_ADDR_WIDTH),
        .TAG_WIDTH(TAG_WIDTH)
    ) wide_bus ();

    mem_bus_if #(
        .DATA_WIDTH(NARROW_DATA_WIDTH),
        .ADDR_WIDTH(NARROW_ADDR_WIDTH),
        .TAG_WIDTH(TAG_WIDTH)
    ) narrow_bus ();

    mem_req_queue #(
        .DATA_WIDTH(WIDE_DATA_WIDTH),
        .ADDR_WIDTH(WIDE_ADDR_WIDTH),
        .TAG_WIDTH(TAG_WIDTH),
        .DEPTH(4)
    ) u_queue (
        .clk(clk),
        .reset(reset),
        .in_valid(req_valid),
        .in_addr(req_addr),
        .in_rw(req_rw),
        .in_byteen(req_byteen),
        .in_data(req_data),
        .in_tag(req_tag),
        .in_ready(req_ready),
        .out(wide_bus.requester)
    );

    mem_width_adapter #(
        .SRC_DATA_WIDTH(WIDE_DATA_WIDTH),
        .DST_DATA_WIDTH(NARROW_DATA_WIDTH),
        .SRC_ADDR_WIDTH(WIDE_ADDR_WIDTH),
        .DST_ADDR_WIDTH(NARROW_ADDR_WIDTH)
    ) u_adapter (
        .clk(clk),
        .reset(reset),
        .src(wide_bus.responder),
        .dst(narrow_bus.requester)
    );

    narrow_ram #(
        .ADDR_WIDTH(NARROW_ADDR_WIDTH)
    ) u_ram (
        .clk(clk),
        .reset(reset),
        .bus(narrow_bus.responder)
    );

    // wide responses leave straight from the adapter.
    assign rsp_valid = wide_bus.rsp_valid;
    assign rsp_data = wide_bus.rsp_data;
    assign rsp_tag = wide_bus.rsp_tag;
    assign wide_bus.rsp_ready = rsp_ready;

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0; // released on an edge like any other input.
    end

endmodule

/* tb/mem_bridge_tb.sv */
`timescale 1ns/1ps

module mem_bridge_tb;
    import mem_bridge_pkg::*;

    localparam int NUM_LINES = 30;
    localparam int NUM_FIELDS = 6;
    localparam int CYCLE_LIMIT = NUM_LINES * 40 + 100;
    localparam logic [15:0] LFSR_SEED = 16'd21290;

    logic clk;
    logic reset;
    logic req_valid;
    wide_addr_t req_addr;
    logic req_rw;
    wide_byteen_t req_byteen;
    wide_data_t req_data;
    tag_t req_tag;
    logic req_ready;
    logic rsp_valid;
    wide_data_t rsp_data;
    tag_t rsp_tag;
    logic rsp_ready = 1'b0;

    wide_data_t patterns [NUM_LINES*NUM_FIELDS];
    wide_data_t exp_data_q [$];
    tag_t exp_tag_q [$];
    logic [15:0] lfsr_state = LFSR_SEED;
    int cycle_count = 0;
    int pause_end = 0;
    int read_count = 0;
    int rsp_count = 0;
    int rsp_passes = 0;
    int rsp_fails = 0;
    int check_passes = 0;
    int check_fails = 0;
    bit saw_full = 1'b0;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock (.clk(clk), .reset(reset));

    mem_bridge_top dut (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_addr(req_addr),
        .req_rw(req_rw),
        .req_byteen(req_byteen),
        .req_data(req_data),
        .req_tag(req_tag),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_data(rsp_data),
        .rsp_tag(rsp_tag),
        .rsp_ready(rsp_ready)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hb400 : 16'h0000);
    endfunction

    task automatic check_data(input wide_data_t got, input wide_data_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Fail %0t: rsp_data %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_tag(input tag_t got, input tag_t exp, output bit ok);
        ok = (got === exp);
        if (!ok) begin
            $display("Fail %0t: rsp_tag %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t: %s is %b expected %b", $time, what, got, exp);
            check_fails++;
        end else begin
            $display("%s: ok", what);
            check_passes++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail %0t: %0d %s expected %0d", $time, got, what, exp);
            check_fails++;
        end else begin
            $display("%0d %s: ok", got, what);
            check_passes++;
        end
    endtask

    task automatic take_response();
        wide_data_t exp_data;
        tag_t exp_tag;
        bit data_ok;
        bit tag_ok;
        rsp_count++;
        if (exp_tag_q.size() == 0) begin
            $display("response %0d with tag %h came with no read outstanding", rsp_count, rsp_tag);
            rsp_fails++;
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_tag = exp_tag_q.pop_front();
            check_data(rsp_data, exp_data, data_ok);
            check_tag(rsp_tag, exp_tag, tag_ok);
            if (data_ok && tag_ok) begin
                $display("read %0d tag %h: ok", rsp_count, rsp_tag);
                rsp_passes++;
            end else begin
                rsp_fails++;
            end
        end
    endtask

    task automatic offer_line(input int line);
        int base;
        base = line * NUM_FIELDS;
        if (patterns[base][1:0] == 2'd2) begin
            pause_end <= cycle_count + int'(patterns[base + 2][7:0]); // address field is the length.
        end else begin
            req_valid <= 1'b1;
            req_rw <= patterns[base][0];
            req_tag <= patterns[base + 1][TAG_WIDTH-1:0];
            req_addr <= patterns[base + 2][WIDE_ADDR_WIDTH-1:0];
            req_byteen <= patterns[base + 3][WIDE_BYTEEN_WIDTH-1:0];
            req_data <= patterns[base + 4];
            if (patterns[base][0] == 1'b0) begin
                exp_tag_q.push_back(patterns[base + 1][TAG_WIDTH-1:0]);
                exp_data_q.push_back(patterns[base + 5]);
                read_count++;
            end
            @(posedge clk);
            while (!req_ready) @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // response back-pressure.
    always @(posedge clk) begin
        if (reset) begin
            rsp_ready <= 1'b0;
        end else if (cycle_count < pause_end) begin
            rsp_ready <= 1'b0;
        end else begin
            rsp_ready <= lfsr_state[0];
            lfsr_state <= lfsr_step(lfsr_state);
        end
    end

    always @(posedge clk) begin
        if (!reset && rsp_valid && rsp_ready) begin
            take_response();
        end
        if (!reset && (cycle_count < pause_end) && req_valid && !req_ready) begin
            saw_full <= 1'b1; // queue backed up during the pause.
        end
    end

    initial begin
        req_valid = 1'b0;
        req_addr = '0;
        req_rw = 1'b0;
        req_byteen = '0;
        req_data = '0;
        req_tag = '0;
        $readmemh("tb/mem_bridge_patterns.hex", patterns);

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
            check_flag(rsp_valid, 1'b0, "rsp_valid in reset");
        end
        @(posedge clk);
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        check_flag(req_ready, 1'b1, "req_ready after reset");

        for (int i = 0; i < NUM_LINES; i++) begin
            offer_line(i);
        end
        req_valid <= 1'b0;

        while (exp_tag_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk); // catch late duplicates.
        check_count(rsp_count, read_count, "responses");
        if (saw_full) begin
            $display("queue filled during the pause: ok");
            check_passes++;
        end else begin
            $display("req_ready never dropped while responses were held");
            check_fails++;
        end

        $display("passed %0d failed %0d", rsp_passes + check_passes, rsp_fails + check_fails);
        if (rsp_fails + check_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb/mem_bridge_patterns.hex */
// op (0 read, 1 write, 2 pause), tag, wide address, byte enable, write data, expected data
// a pause line holds rsp_ready low for the number of cycles in its address column
1 1 00 ffff 00112233445566778899aabbccddeeff 0
0 2 00 0 0 00112233445566778899aabbccddeeff
1 3 01 ffff 0f0e0d0c0b0a09080706050403020100 0
0 4 01 0 0 0f0e0d0c0b0a09080706050403020100
1 5 02 ffff 11111111222222223333333344444444 0
0 6 02 0 0 11111111222222223333333344444444
1 7 00 8001 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 0
0 8 00 0 0 5a112233445566778899aabbccddee5a
1 9 01 0f0f a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 0
0 a 01 0 0 0f0e0d0ca5a5a5a507060504a5a5a5a5
1 b 02 2480 99999999999999999999999999999999 0
0 c 02 0 0 11119911229922229933333344444444
2 0 30 0 0 0
0 9 00 0 0 5a112233445566778899aabbccddee5a
0 a 01 0 0 0f0e0d0ca5a5a5a507060504a5a5a5a5
0 b 02 0 0 11119911229922229933333344444444
0 c 00 0 0 5a112233445566778899aabbccddee5a
0 d 01 0 0 0f0e0d0ca5a5a5a507060504a5a5a5a5
0 e 02 0 0 11119911229922229933333344444444
1 0 10 ffff 89abcdef01234567fedcba9876543210 0
0 f 10 0 0 89abcdef01234567fedcba9876543210
1 1 ff ffff cafef00ddeadbeef123456789abcdef0 0
0 0 ff 0 0 cafef00ddeadbeef123456789abcdef0
1 2 ff f000 0 0
0 1 ff 0 0 00000000deadbeef123456789abcdef0
0 2 10 0 0 89abcdef01234567fedcba9876543210
1 3 10 000f 11111111111111111111111111111111 0
0 3 10 0 0 89abcdef01234567fedcba9811111111
0 4 00 0 0 5a112233445566778899aabbccddee5a
0 5 01 0 0 0f0e0d0ca5a5a5a507060504a5a5a5a5

/* mem_bridge_top.f */
logic/mem_bridge_pkg.sv
logic/mem_bus_if.sv
logic/mem_req_queue.sv
logic/mem_width_adapter.sv
logic/narrow_ram.sv
logic/mem_bridge_top.sv
tb/tb_clock_gen.sv
tb/mem_bridge_tb.sv

/* Makefile */
TOP := mem_bridge_tb
SIM := obj_dir/V$(TOP)
SRCS := $(shell cat mem_bridge_top.f)

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

$(SIM): mem_bridge_top.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f mem_bridge_top.f --top-module $(TOP) -Mdir obj_dir

clean:
	rm -rf obj_dir
